/* all.f */
source/soc_pkg.sv
source/uart_tx.sv
source/uart_rx.sv
source/word_ram.sv
source/uart_regs.sv
source/bus_mux.sv
source/soc_bus.sv
test/bus_checker.sv
test/tb_soc_bus.sv

/* run.sh */
#!/bin/sh
# build with verilator, run, then look for the fail message
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_soc_bus -f all.f --Mdir obj_dir -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "Some tests failed" sim.log; then
  exit 1
fi
exit 0

/* source/bus_mux.sv */
`timescale 1ns/10ps

module bus_mux import soc_pkg::*; #(
  parameter int ram_words = 256
) (
  input  logic     clk,
  input  logic     resetn,
  input  bus_req_t req,
  output logic     ram_sel,
  output logic     uart_sel,
  input  bus_rsp_t ram_rsp,
  input  bus_rsp_t uart_rsp,
  output bus_rsp_t rsp
);

  localparam logic [31:0] ram_end = 32'(ram_words * 4);

  logic in_ram;
  logic in_uart;
  logic accept;
  logic unmapped_sel;
  logic unmapped_rdy;
  logic rsp_ready;

  //////////////////////////////////////////////////////////////////////
  // region decode

  assign in_ram  = (req.addr < ram_end);
  assign in_uart = (req.addr >= uart_base) && (req.addr < uart_base + uart_span);

  // no new accept while a response is returning
  assign accept       = req.valid && !rsp_ready;
  assign ram_sel      = accept && in_ram;
  assign uart_sel     = accept && in_uart;
  assign unmapped_sel = accept && !in_ram && !in_uart;

  always_ff @(posedge clk) begin
    if (!resetn) unmapped_rdy <= 1'b0;
    else         unmapped_rdy <= unmapped_sel;  // answers zero, no effect
  end

  //////////////////////////////////////////////////////////////////////
  // response merge

  assign rsp_ready = ram_rsp.ready || uart_rsp.ready || unmapped_rdy;

  always_comb begin
    rsp.ready = rsp_ready;
    if (ram_rsp.ready)       rsp.rdata = ram_rsp.rdata;
    else if (uart_rsp.ready) rsp.rdata = uart_rsp.rdata;
    else                     rsp.rdata = '0;  // unmapped or idle
  end

endmodule

/* source/soc_bus.sv */
`timescale 1ns/10ps

module soc_bus import soc_pkg::*; #(
  parameter int ram_words    = 256,
  parameter int clks_per_bit = 8
) (
  input  logic     clk,
  input  logic     resetn,
  input  bus_req_t req,
  output bus_rsp_t rsp,
  output logic     uart_tx,
  input  logic     uart_rx
);

  logic     ram_sel;
  logic     uart_sel;
  bus_rsp_t ram_rsp;
  bus_rsp_t uart_rsp;

  bus_mux #(.ram_words(ram_words)) mux_i (
    .clk(clk), .resetn(resetn), .req(req),
    .ram_sel(ram_sel), .uart_sel(uart_sel),
    .ram_rsp(ram_rsp), .uart_rsp(uart_rsp), .rsp(rsp)
  );

  // slaves share the request wires
  word_ram #(.ram_words(ram_words)) ram_i (
    .clk(clk), .resetn(resetn), .sel(ram_sel),
    .addr(req.addr), .wdata(req.wdata), .wstrb(req.wstrb),
    .rsp(ram_rsp)
  );

  uart_regs #(.clks_per_bit(clks_per_bit)) uart_i (
    .clk(clk), .resetn(resetn), .sel(uart_sel),
    .addr(req.addr), .wdata(req.wdata), .wstrb(req.wstrb),
    .rsp(uart_rsp), .tx_line(uart_tx), .rx_line(uart_rx)
  );

endmodule

/* source/soc_pkg.sv */
package soc_pkg;

  //////////////////////////////////////////////////////////////////////
  // bus request and response

  typedef struct packed {
    logic        valid;
    logic [31:0] addr;   // byte address
    logic [31:0] wdata;
    logic [3:0]  wstrb;  // any bit set means write
  } bus_req_t;

  typedef struct packed {
    logic        ready;  // one-cycle pulse
    logic [31:0] rdata;  // valid with ready only
  } bus_rsp_t;

  //////////////////////////////////////////////////////////////////////
  // address map

  localparam logic [31:0] uart_base    = 32'h1000_0000;
  localparam logic [31:0] uart_span    = 32'd16;
  localparam logic [1:0]  uart_tx_off  = 2'd0;   // word offsets
  localparam logic [1:0]  uart_rx_off  = 2'd1;
  localparam logic [1:0]  uart_lsr_off = 2'd2;

  // line status word
  localparam int          lsr_rx_avail_bit = 0;
  localparam int          lsr_tx_idle_bit  = 5;
  localparam logic [31:0] rx_empty_word    = 32'hffff_ffff;

endpackage

/* source/uart_regs.sv */
`timescale 1ns/10ps

module uart_regs import soc_pkg::*; #(
  parameter int clks_per_bit = 8
) (
  input  logic        clk,
  input  logic        resetn,
  input  logic        sel,
  input  logic [31:0] addr,
  input  logic [31:0] wdata,
  input  logic [3:0]  wstrb,
  output bus_rsp_t    rsp,
  output logic        tx_line,
  input  logic        rx_line
);

  logic [1:0]  off;
  logic        wr;
  logic        tx_busy;
  logic        rx_avail;
  logic [7:0]  rx_data;
  logic        rx_pop;
  logic        tx_start;
  logic [31:0] lsr;
  logic        ready_q;
  logic [31:0] rdata_q;

  assign off      = addr[3:2];
  assign wr       = |wstrb;
  assign tx_start = sel && wr && (off == uart_tx_off);  // dropped by tx when busy
  assign rx_pop   = sel && !wr && (off == uart_rx_off);

  always_comb begin
    lsr                   = '0;
    lsr[lsr_rx_avail_bit] = rx_avail;
    lsr[lsr_tx_idle_bit]  = !tx_busy;
  end

  //////////////////////////////////////////////////////////////////////
  // read data and ack

  always_ff @(posedge clk) begin
    if (sel) begin
      rdata_q <= '0;  // writes and other offsets
      if (!wr && off == uart_rx_off) rdata_q <= rx_avail ? {24'b0, rx_data} : rx_empty_word;
      if (!wr && off == uart_lsr_off) rdata_q <= lsr;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) ready_q <= 1'b0;
    else         ready_q <= sel;
  end

  assign rsp = '{ready: ready_q, rdata: rdata_q};

  uart_tx #(.clks_per_bit(clks_per_bit)) tx_i (
    .clk(clk), .resetn(resetn), .start(tx_start), .data(wdata[7:0]),
    .line(tx_line), .busy(tx_busy)
  );

  uart_rx #(.clks_per_bit(clks_per_bit)) rx_i (
    .clk(clk), .resetn(resetn), .line(rx_line), .pop(rx_pop),
    .data(rx_data), .avail(rx_avail)
  );

endmodule

/* source/uart_rx.sv */
`timescale 1ns/10ps

module uart_rx #(
  parameter int clks_per_bit = 8
) (
  input  logic       clk,
  input  logic       resetn,
  input  logic       line,
  input  logic       pop,
  output logic [7:0] data,
  output logic       avail
);

  localparam int cw      = $clog2(clks_per_bit + 1);
  localparam int half_m1 = (clks_per_bit / 2 > 0) ? clks_per_bit / 2 - 1 : 0;

  typedef enum logic [1:0] {rx_idle, rx_start, rx_data, rx_stop} rx_state_t;

  rx_state_t     state;
  logic [1:0]    sync;      // two-flop synchronizer
  logic [cw-1:0] clk_cnt;
  logic [2:0]    bit_idx;
  logic [7:0]    shreg;
  logic          bit_end;

  assign bit_end = (clk_cnt == cw'(clks_per_bit - 1));

  always_ff @(posedge clk) begin
    if (!resetn) begin
      sync    <= 2'b11;
      state   <= rx_idle;
      clk_cnt <= '0;
      bit_idx <= '0;
      avail   <= 1'b0;
    end else begin
      sync    <= {sync[0], line};
      clk_cnt <= clk_cnt + 1'b1;
      if (pop) avail <= 1'b0;
      case (state)
        rx_idle: begin
          clk_cnt <= '0;
          if (!sync[1]) state <= rx_start;  // falling edge
        end
        rx_start: if (clk_cnt == cw'(half_m1)) begin
          clk_cnt <= '0;
          bit_idx <= '0;
          state   <= sync[1] ? rx_idle : rx_data;  // glitch check
        end
        rx_data: if (bit_end) begin
          clk_cnt <= '0;
          shreg   <= {sync[1], shreg[7:1]};
          bit_idx <= bit_idx + 3'd1;
          if (bit_idx == 3'd7) state <= rx_stop;
        end
        rx_stop: if (bit_end) begin
          state <= rx_idle;
          if (sync[1]) begin    // bad stop bit drops the frame
            data  <= shreg;     // overwrites an unread byte
            avail <= 1'b1;
          end
        end
        default: state <= rx_idle;
      endcase
    end
  end

endmodule

/* source/uart_tx.sv */
`timescale 1ns/10ps

module uart_tx #(
  parameter int clks_per_bit = 8
) (
  input  logic       clk,
  input  logic       resetn,
  input  logic       start,
  input  logic [7:0] data,
  output logic       line,
  output logic       busy
);

  localparam int cw = $clog2(clks_per_bit + 1);

  logic [cw-1:0] clk_cnt;
  logic [3:0]    bit_idx;   // 0 start, 1..8 data, 9 stop
  logic [8:0]    shreg;     // data bits then stop bit

  always_ff @(posedge clk) begin
    if (!resetn) begin
      line    <= 1'b1;
      busy    <= 1'b0;
      clk_cnt <= '0;
      bit_idx <= '0;
    end else if (!busy) begin
      if (start) begin
        shreg   <= {1'b1, data};
        line    <= 1'b0;        // start bit
        busy    <= 1'b1;
        clk_cnt <= '0;
        bit_idx <= '0;
      end
    end else if (clk_cnt == cw'(clks_per_bit - 1)) begin
      clk_cnt <= '0;
      if (bit_idx == 4'd9) begin
        busy <= 1'b0;           // stop bit done
      end else begin
        line    <= shreg[0];    // lsb first
        shreg   <= {1'b1, shreg[8:1]};
        bit_idx <= bit_idx + 4'd1;
      end
    end else begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

endmodule

/* source/word_ram.sv */
`timescale 1ns/10ps

module word_ram import soc_pkg::*; #(
  parameter int ram_words = 256
) (
  input  logic        clk,
  input  logic        resetn,
  input  logic        sel,
  input  logic [31:0] addr,
  input  logic [31:0] wdata,
  input  logic [3:0]  wstrb,
  output bus_rsp_t    rsp
);

  localparam int aw = (ram_words > 1) ? $clog2(ram_words) : 1;

  logic [31:0]   mem [ram_words];
  logic [aw-1:0] idx;
  logic          ready_q;
  logic [31:0]   rdata_q;

  assign idx = addr[aw+1:2];  // word index, byte offset dropped

  always_ff @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (sel && wstrb[i]) mem[idx][8*i +: 8] <= wdata[8*i +: 8];
    end
    if (sel) rdata_q <= mem[idx];  // old word on write
  end

  always_ff @(posedge clk) begin
    if (!resetn) ready_q <= 1'b0;
    else         ready_q <= sel;
  end

  assign rsp = '{ready: ready_q, rdata: rdata_q};

endmodule

/* test/bus_checker.sv */
`timescale 1ns/10ps

module bus_checker import soc_pkg::*; #(
  parameter int clks_per_bit = 8
) (
  input  logic        clk,
  input  logic        resetn,
  input  bus_req_t    req,
  input  bus_rsp_t    rsp,
  input  logic        uart_tx,
  input  logic        check_en,
  input  logic [31:0] exp_rdata,
  input  logic [7:0]  exp_tx_byte,
  output int          errors,
  output int          frames
);

  logic       pend;      // request taken at the coming edge
  logic       started;   // first request seen
  logic       in_frame;
  int         scnt;      // negedges since start bit seen
  int         sbit;      // 0 start, 1..8 data, 9 stop
  logic [7:0] sbyte;

  // everything sampled mid-cycle away from the rising edge
  always @(negedge clk) begin
    if (!resetn) begin
      pend     = 1'b0;
      started  = 1'b0;
      in_frame = 1'b0;
      errors   = 0;
      frames   = 0;
    end else begin
      //////////////////////////////////////////////////////////////////////
      // bus response
      if (rsp.ready !== pend) begin
        $display("Error at %0t: rsp.ready expected %b, got %b", $time, pend, rsp.ready);
        errors++;
      end
      if (rsp.ready === 1'b1 && check_en && rsp.rdata !== exp_rdata) begin
        $display("Error at %0t: rsp.rdata expected %h, got %h", $time, exp_rdata, rsp.rdata);
        errors++;
      end
      pend = req.valid && !pend;  // no accept in the cycle a response returns

      // line stays idle until the first request
      if (!started && uart_tx !== 1'b1) begin
        $display("Error at %0t: uart_tx expected 1, got %b", $time, uart_tx);
        errors++;
      end
      if (req.valid === 1'b1) started = 1'b1;

      //////////////////////////////////////////////////////////////////////
      // serial frame decode
      if (!in_frame) begin
        if (uart_tx === 1'b0) begin  // start edge seen half a cycle late
          in_frame = 1'b1;
          scnt     = 0;
          sbit     = 0;
        end
      end else begin
        scnt++;
        if (scnt == clks_per_bit / 2 + sbit * clks_per_bit) begin  // mid-bit
          if (sbit == 0 && uart_tx !== 1'b0) begin
            $display("uart_tx start bit went high again at %0t", $time);
            errors++;
            in_frame = 1'b0;
          end else if (sbit >= 1 && sbit <= 8) begin
            sbyte = {uart_tx, sbyte[7:1]};  // lsb first
          end else if (sbit == 9) begin
            in_frame = 1'b0;
            frames++;
            if (uart_tx !== 1'b1) begin
              $display("uart_tx stop bit was low at %0t", $time);
              errors++;
            end else if (sbyte !== exp_tx_byte) begin
              $display("Error at %0t: uart_tx byte expected %h, got %h",
                       $time, exp_tx_byte, sbyte);
              errors++;
            end
          end
          sbit++;
        end
      end
    end
  end

endmodule

/* test/tb_soc_bus.sv */
`timescale 1ns/10ps

module tb_soc_bus import soc_pkg::*; ();

  localparam int clks_per_bit = 8;
  localparam int ram_words    = 256;
  localparam int ready_limit  = 10;   // cycles per access
  localparam int poll_limit   = 200;  // status reads per poll
  localparam int n_steps      = 23;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        chk;
    logic [31:0] exp;
    logic [31:0] poll;  // status bits to wait for
  } step_t;

  logic        clk;
  logic        resetn;
  bus_req_t    req;
  bus_rsp_t    rsp;
  logic        serial;  // uart_tx looped to uart_rx
  logic        check_en;
  logic [31:0] exp_rdata;
  logic [7:0]  exp_tx_byte;
  int          chk_errors;
  int          frames;
  int          tb_errors;
  int          timeouts;
  int          tx_writes;
  step_t       steps [n_steps];

  initial clk = 1'b0;
  always #20 clk = ~clk;

  soc_bus #(.ram_words(ram_words), .clks_per_bit(clks_per_bit)) uut (
    .clk(clk), .resetn(resetn), .req(req), .rsp(rsp),
    .uart_tx(serial), .uart_rx(serial)
  );

  bus_checker #(.clks_per_bit(clks_per_bit)) mon_i (
    .clk(clk), .resetn(resetn), .req(req), .rsp(rsp), .uart_tx(serial),
    .check_en(check_en), .exp_rdata(exp_rdata), .exp_tx_byte(exp_tx_byte),
    .errors(chk_errors), .frames(frames)
  );

  // called 1 ns after a rising edge, returns 1 ns after the edge ending ready
  task automatic run_access(input step_t s, output logic [31:0] rd);
    int waited;
    waited    = 0;
    req       = '{valid: 1'b1, addr: s.addr, wdata: s.wdata, wstrb: s.wstrb};
    check_en  = s.chk;
    exp_rdata = s.exp;
    do begin
      @(negedge clk);
      waited++;
    end while (rsp.ready !== 1'b1 && waited < ready_limit);
    if (rsp.ready !== 1'b1) begin
      $display("no ready within %0d cycles for address %h", ready_limit, s.addr);
      timeouts++;
    end
    rd = rsp.rdata;
    @(posedge clk);
    #1;
    req.valid = 1'b0;
    check_en  = 1'b0;
  endtask

  initial begin
    logic [31:0] rd;
    int          tries;
    int          total;
    resetn      = 1'b0;
    req         = '0;
    check_en    = 1'b0;
    exp_rdata   = '0;
    exp_tx_byte = '0;
    tb_errors   = 0;
    timeouts    = 0;
    tx_writes   = 0;
    //          addr           wdata          wstrb    chk   exp            poll
    steps = '{
      '{32'h0000_0010, 32'h1122_3344, 4'b1111, 1'b0, 32'h0,         32'h0},
      '{32'h0000_0014, 32'hcafe_f00d, 4'b1111, 1'b0, 32'h0,         32'h0},
      '{32'h0000_0010, 32'hdead_be99, 4'b0001, 1'b0, 32'h0,         32'h0},
      '{32'h0000_0010, 32'h55aa_77ff, 4'b0100, 1'b0, 32'h0,         32'h0},
      '{32'h0000_0010, 32'h0,         4'b0000, 1'b1, 32'h11aa_3399, 32'h0},
      '{32'h0000_0010, 32'h6600_0000, 4'b1010, 1'b0, 32'h0,         32'h0},
      '{32'h0000_0010, 32'h0,         4'b0000, 1'b1, 32'h66aa_0099, 32'h0},
      '{32'h0000_0014, 32'h0,         4'b0000, 1'b1, 32'hcafe_f00d, 32'h0},
      // unmapped space where 0x410 would alias word 0x10
      '{32'h2000_0000, 32'h0,         4'b0000, 1'b1, 32'h0,         32'h0},
      '{32'h0000_0410, 32'hffff_ffff, 4'b1111, 1'b1, 32'h0,         32'h0},
      '{32'h0000_0410, 32'h0,         4'b0000, 1'b1, 32'h0,         32'h0},
      '{32'h1000_0010, 32'h0,         4'b0000, 1'b1, 32'h0,         32'h0},
      '{32'h0000_0010, 32'h0,         4'b0000, 1'b1, 32'h66aa_0099, 32'h0},
      // uart status, empty rx, tx byte and loopback
      '{32'h1000_0008, 32'h0,         4'b0000, 1'b1, 32'h0000_0020, 32'h0},
      '{32'h1000_0004, 32'h0,         4'b0000, 1'b1, 32'hffff_ffff, 32'h0},
      '{32'h1000_0000, 32'h0000_00a5, 4'b0001, 1'b1, 32'h0,         32'h0},
      '{32'h1000_0008, 32'h0,         4'b0000, 1'b1, 32'h0,         32'h0},
      '{32'h1000_0008, 32'h0,         4'b0000, 1'b0, 32'h0,         32'h20},
      '{32'h1000_0008, 32'h0,         4'b0000, 1'b0, 32'h0,         32'h01},
      '{32'h1000_0004, 32'h0,         4'b0000, 1'b1, 32'h0000_00a5, 32'h0},
      '{32'h1000_0004, 32'h0,         4'b0000, 1'b1, 32'hffff_ffff, 32'h0},
      '{32'h1000_0008, 32'h0,         4'b0000, 1'b1, 32'h0000_0020, 32'h0},
      '{32'h1000_0008, 32'hffff_ffff, 4'b1111, 1'b1, 32'h0,         32'h0}
    };
    repeat (3) @(posedge clk);
    #1;
    resetn = 1'b1;

    // idle bus for a few cycles before the first request
    repeat (4) @(posedge clk);
    #1;

    //////////////////////////////////////////////////////////////////////
    // table
    foreach (steps[i]) begin
      if (steps[i].addr == uart_base + {28'h0, uart_tx_off, 2'b00} && steps[i].wstrb != 4'h0) begin
        exp_tx_byte = steps[i].wdata[7:0];
        tx_writes++;
      end
      tries = 0;
      do begin
        run_access(steps[i], rd);
        tries++;
      end while (steps[i].poll != 32'h0 && (rd & steps[i].poll) == 32'h0 && tries < poll_limit);
      if (steps[i].poll != 32'h0 && (rd & steps[i].poll) == 32'h0) begin
        $display("status bit %h never came up after %0d reads", steps[i].poll, tries);
        timeouts++;
      end
    end

    repeat (2) @(posedge clk);
    if (frames != tx_writes) begin
      $display("uart_tx carried %0d frames for %0d tx writes", frames, tx_writes);
      tb_errors++;
    end
    total = chk_errors + tb_errors + timeouts;
    $display("errors %0d: checker %0d, testbench %0d, timeouts %0d",
             total, chk_errors, tb_errors, timeouts);
    if (total == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
